// ==== subway_map_pkg.sv ====
`default_nettype none

package subway_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // track geometry
    //////////////////////////////////////////////////////////////////////

    localparam int LANES        = 4;   // tracks on the map
    localparam int MAP_COLS_DEF = 64;  // default map length in columns
    localparam int SEG_LEN      = 8;   // columns per segment, gate at offset 0

    //////////////////////////////////////////////////////////////////////
    // cell codes
    //////////////////////////////////////////////////////////////////////

    // codes 2 and 3 are solid obstacles, only free and low matter here
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_FREE = 2'd0;  // nothing on the track
    localparam cell_t CELL_LOW  = 2'd1;  // low barrier, can be jumped

    // lane 0 is the leftmost track
    typedef logic [1:0] lane_t;

endpackage

`default_nettype wire

// ==== subway_action_pkg.sv ====
`default_nettype none

package subway_action_pkg;

    //////////////////////////////////////////////////////////////////////
    // runner actions, one per column
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ACT_FWD   = 2'd0,  // keep running in the lane
        ACT_RIGHT = 2'd1,  // one lane up
        ACT_LEFT  = 2'd2,  // one lane down
        ACT_JUMP  = 2'd3   // hop over a low barrier
    } action_t;

    //////////////////////////////////////////////////////////////////////
    // offsets inside a segment
    //////////////////////////////////////////////////////////////////////

    // jump slots, looking one column ahead
    localparam int OFF_JUMP_A = 1;
    localparam int OFF_JUMP_B = 3;
    localparam int OFF_JUMP_C = 5;

    // staged lane changes toward the next gate
    localparam int OFF_MOVE_1 = 4;  // first step, any distance
    localparam int OFF_MOVE_2 = 6;  // second step, distance above 1
    localparam int OFF_MOVE_3 = 7;  // third step, distance above 2

endpackage

`default_nettype wire

// ==== map_read_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface map_read_if
    import subway_map_pkg::*;
#(
    parameter int MAP_COLS
) ();

    localparam int CW = $clog2(MAP_COLS);

    logic [CW-1:0]          jump_col;    // column looked at for a jump
    lane_t                  jump_lane;   // lane looked at for a jump
    cell_t                  jump_cell;   // cell at jump_lane/jump_col
    logic [CW-1:0]          gate_col;    // gate column of the next segment
    cell_t [LANES-1:0]      gate_cells;  // all lanes of gate_col
    lane_t                  start_lane;  // init captured with column 0

    // map storage side
    modport store (
        input  jump_col, jump_lane, gate_col,
        output jump_cell, gate_cells, start_lane
    );

    // route planner side
    modport reader (
        output jump_col, jump_lane, gate_col,
        input  jump_cell, gate_cells, start_lane
    );

endinterface

`default_nettype wire

// ==== subway_map_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module subway_map_store
    import subway_map_pkg::*;
#(
    parameter int MAP_COLS
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   in_valid,
    input  wire lane_t  init,
    input  wire cell_t  in0,
    input  wire cell_t  in1,
    input  wire cell_t  in2,
    input  wire cell_t  in3,
    map_read_if.store   rd,
    output logic        map_loaded
);

    localparam int CW = $clog2(MAP_COLS);

    cell_t             map_mem [LANES][MAP_COLS];  // lane major
    cell_t [LANES-1:0] col_in;
    logic  [CW-1:0]    load_col;
    logic              in_valid_q;
    lane_t             start_lane_q;

    assign col_in = {in3, in2, in1, in0};

    //////////////////////////////////////////////////////////////////////
    // loading
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int l = 0; l < LANES; l++) begin
                map_mem[l][load_col] <= col_in[l];  // one column per cycle
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_col     <= '0;
            in_valid_q   <= 1'b0;
            start_lane_q <= '0;
        end else begin
            in_valid_q <= in_valid;
            if (in_valid) begin
                load_col <= load_col + 1'b1;
            end else begin
                load_col <= '0;  // ready for the next map
            end
            if (in_valid && load_col == '0) begin
                start_lane_q <= init;
            end
        end
    end

    // high in the first idle cycle after the last column
    assign map_loaded = in_valid_q & ~in_valid;

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    assign rd.jump_cell  = map_mem[rd.jump_lane][rd.jump_col];
    assign rd.start_lane = start_lane_q;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rd.gate_cells[l] = map_mem[l][rd.gate_col];
        end
    end

endmodule

`default_nettype wire

// ==== subway_route_planner.sv ====
`timescale 1ns/10ps
`default_nettype none

module subway_route_planner
    import subway_map_pkg::*;
    import subway_action_pkg::*;
#(
    parameter int MAP_COLS
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [$clog2(MAP_COLS)-1:0]  step,
    input  wire logic                         step_en,
    map_read_if.reader                        rd,
    output action_t                           action
);

    localparam int CW = $clog2(MAP_COLS);
    localparam int OW = $clog2(SEG_LEN);
    localparam logic [CW-1:0] LAST_SEG_START = CW'(MAP_COLS - SEG_LEN);

    lane_t             lane_q;       // lane the runner is in
    lane_t             target_q;     // target lane of this segment
    logic signed [2:0] dist_q;       // lane minus target at segment start
    lane_t             cur_lane;
    lane_t             gate_target;
    logic signed [2:0] gate_dist;
    logic        [1:0] dist_mag;
    logic     [OW-1:0] offset;
    logic              last_seg;
    logic              jump_slot;
    logic              move_req;

    assign offset   = step[OW-1:0];
    assign last_seg = (step >= LAST_SEG_START);

    // lane_q still holds the previous run during step 0
    assign cur_lane = (step == '0) ? rd.start_lane : lane_q;

    //////////////////////////////////////////////////////////////////////
    // gate target
    //////////////////////////////////////////////////////////////////////

    // only sampled at offset 0, where this is the next segment start
    assign rd.gate_col = step + CW'(SEG_LEN);

    always_comb begin
        gate_target = lane_t'(LANES - 1);  // fallback when 0..2 are blocked
        for (int l = LANES - 2; l >= 0; l--) begin
            if (rd.gate_cells[l] == CELL_FREE) begin
                gate_target = lane_t'(l);
            end
        end
    end

    assign gate_dist = signed'({1'b0, cur_lane}) - signed'({1'b0, gate_target});
    assign dist_mag  = dist_q[2] ? 2'(-dist_q) : dist_q[1:0];

    //////////////////////////////////////////////////////////////////////
    // action decision
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (offset)
            OFF_MOVE_1: move_req = (dist_mag > 2'd0);
            OFF_MOVE_2: move_req = (dist_mag > 2'd1);
            OFF_MOVE_3: move_req = (dist_mag > 2'd2);
            default:    move_req = 1'b0;
        endcase
    end

    assign jump_slot = (offset == OFF_JUMP_A) ||
                       (offset == OFF_JUMP_B) ||
                       (offset == OFF_JUMP_C);

    assign rd.jump_col  = step + 1'b1;  // look one column ahead
    assign rd.jump_lane = lane_q;

    always_comb begin
        action = ACT_FWD;
        if (move_req) begin
            // lane 0 is on the left
            action = (lane_q > target_q) ? ACT_LEFT : ACT_RIGHT;
        end else if (jump_slot && rd.jump_cell == CELL_LOW) begin
            action = ACT_JUMP;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lane and segment registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_q   <= '0;
            target_q <= '0;
            dist_q   <= '0;
        end else if (step_en) begin
            if (offset == '0) begin
                // no gate after the last segment, stay put
                target_q <= last_seg ? cur_lane : gate_target;
                dist_q   <= last_seg ? 3'sd0 : gate_dist;
            end
            if (step == '0) begin
                lane_q <= rd.start_lane;
            end else if (action == ACT_LEFT) begin
                lane_q <= lane_q - 2'd1;
            end else if (action == ACT_RIGHT) begin
                lane_q <= lane_q + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== subway_play_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module subway_play_seq
    import subway_action_pkg::*;
#(
    parameter int MAP_COLS
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         map_loaded,
    input  wire action_t                      action,
    output logic [$clog2(MAP_COLS)-1:0]       step,
    output logic                              step_en,
    output logic                              out_valid,
    output action_t                           out
);

    localparam int CW = $clog2(MAP_COLS);
    localparam logic [CW-1:0] LAST_STEP = CW'(MAP_COLS - 1);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_PLAY = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;

    //////////////////////////////////////////////////////////////////////
    // idle/play FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (map_loaded) state_d = ST_PLAY;
            ST_PLAY: if (step == LAST_STEP) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    assign step_en = (state_q == ST_PLAY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            step    <= '0;
        end else begin
            state_q <= state_d;
            if (step_en) begin
                step <= step + 1'b1;  // wraps to 0 after the last column
            end else begin
                step <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stage, one cycle behind step
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= ACT_FWD;
        end else begin
            out_valid <= step_en;
            out       <= step_en ? action : ACT_FWD;  // zero while idle
        end
    end

endmodule

`default_nettype wire

// ==== subway_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module subway_top
    import subway_map_pkg::*;
    import subway_action_pkg::*;
#(
    parameter int MAP_COLS = MAP_COLS_DEF
) (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   in_valid,
    input  wire lane_t  init,
    input  wire cell_t  in0,
    input  wire cell_t  in1,
    input  wire cell_t  in2,
    input  wire cell_t  in3,
    output logic        out_valid,
    output action_t     out
);

    localparam int CW = $clog2(MAP_COLS);

    logic          map_loaded;
    logic [CW-1:0] step;
    logic          step_en;
    action_t       action;

    map_read_if #(.MAP_COLS(MAP_COLS)) rd_if ();

    subway_map_store #(.MAP_COLS(MAP_COLS)) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .init       (init),
        .in0        (in0),
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .rd         (rd_if.store),
        .map_loaded (map_loaded)
    );

    subway_route_planner #(.MAP_COLS(MAP_COLS)) u_planner (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .step_en (step_en),
        .rd      (rd_if.reader),
        .action  (action)
    );

    subway_play_seq #(.MAP_COLS(MAP_COLS)) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .map_loaded (map_loaded),
        .action     (action),
        .step       (step),
        .step_en    (step_en),
        .out_valid  (out_valid),
        .out        (out)
    );

endmodule

`default_nettype wire

// ==== subway_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module subway_checker
    import subway_map_pkg::*;
    import subway_action_pkg::*;
#(
    parameter int MAP_COLS
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    in_valid,
    input  wire lane_t   init,
    input  wire cell_t   in0,
    input  wire cell_t   in1,
    input  wire cell_t   in2,
    input  wire cell_t   in3,
    input  wire logic    out_valid,
    input  wire action_t out,
    output int           tests_done,
    output int           tests_failed,
    output int           err_count
);

    cell_t   map_cap [MAP_COLS][LANES];
    action_t exp_act [MAP_COLS];
    lane_t   start_cap;
    int      load_cnt, wait_cnt, vcount, test_errs;
    logic    in_valid_d, pending, playing;

    // reference model of the lane runner
    task automatic build_expected();
        int   lane, tgt, d, mag, off;
        logic mv;
        lane = start_cap;
        tgt  = lane;
        d    = 0;
        for (int c = 0; c < MAP_COLS; c++) begin
            off = c % SEG_LEN;
            if (off == 0) begin
                tgt = lane;  // last segment keeps its lane
                if (c < MAP_COLS - SEG_LEN) begin
                    tgt = LANES - 1;
                    for (int l = LANES - 2; l >= 0; l--)
                        if (map_cap[c + SEG_LEN][l] == CELL_FREE) tgt = l;
                end
                d = lane - tgt;
            end
            mag = (d < 0) ? -d : d;
            mv  = (off == OFF_MOVE_1 && mag > 0) || (off == OFF_MOVE_2 && mag > 1) ||
                  (off == OFF_MOVE_3 && mag > 2);
            exp_act[c] = ACT_FWD;
            if (mv) begin
                exp_act[c] = (lane > tgt) ? ACT_LEFT : ACT_RIGHT;
                lane       = (lane > tgt) ? lane - 1 : lane + 1;
            end else if ((off == OFF_JUMP_A || off == OFF_JUMP_B || off == OFF_JUMP_C) &&
                         c + 1 < MAP_COLS && map_cap[c + 1][lane] == CELL_LOW) begin
                exp_act[c] = ACT_JUMP;
            end
        end
    endtask

    task automatic flag(input string msg);
        $display("%s at t=%0t", msg, $time);
        err_count++;
        test_errs++;
    endtask

    task automatic close_test();
        tests_done++;
        if (test_errs != 0) tests_failed++;
        $display("test %0d: %s, %0d errors", tests_done,
                 (test_errs == 0) ? "ok" : "FAILED", test_errs);
    endtask

    // sampled on the falling edge, away from both drive edges
    always @(negedge clk) begin
        if (!rst_n) begin
            {tests_done, tests_failed, err_count} = '0;
            {load_cnt, wait_cnt, vcount, test_errs} = '0;
            {in_valid_d, pending, playing} = '0;
        end else begin
            if (pending) wait_cnt++;
            if (in_valid) begin
                if (load_cnt == 0) start_cap = init;
                if (load_cnt < MAP_COLS) map_cap[load_cnt] = '{in0, in1, in2, in3};
                load_cnt++;
            end
            if (out_valid) begin
                if (pending) begin
                    if (wait_cnt != 2) flag($sformatf(
                        "out_valid rose %0d cycles after in_valid fell, not 2", wait_cnt));
                    pending = 1'b0;
                    playing = 1'b1;
                    vcount  = 0;
                end else if (!playing) begin
                    flag("out_valid high with no map loaded");
                end
                if (vcount < MAP_COLS && out !== exp_act[vcount]) begin
                    $display("Fail t=%0t out step %0d: expected %0d got %0d",
                             $time, vcount, exp_act[vcount], out);
                    err_count++;
                    test_errs++;
                end
                vcount++;
            end else begin
                if (out !== ACT_FWD) begin
                    $display("Fail t=%0t out idle: expected 0 got %0d", $time, out);
                    err_count++;
                    test_errs++;
                end
                if (playing) begin
                    if (vcount != MAP_COLS)
                        flag($sformatf("out_valid lasted %0d cycles, not %0d",
                                       vcount, MAP_COLS));
                    playing = 1'b0;
                    close_test();
                end
            end
            if (pending && wait_cnt > 8) begin
                flag("out_valid never rose after the map was loaded");
                pending = 1'b0;
                close_test();
            end
            if (in_valid_d && !in_valid) begin
                test_errs = 0;
                if (load_cnt != MAP_COLS)
                    flag($sformatf("map had %0d columns instead of %0d",
                                   load_cnt, MAP_COLS));
                build_expected();
                pending   = 1'b1;
                wait_cnt  = 0;
                load_cnt  = 0;
            end
            in_valid_d = in_valid;
        end
    end

endmodule

`default_nettype wire

// ==== tb_subway_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_subway_top
    import subway_map_pkg::*;
    import subway_action_pkg::*;
();

    localparam int MAP_COLS = MAP_COLS_DEF;
    localparam int N_TESTS  = 6;
    localparam int K_FREE   = 0;  // every cell free
    localparam int K_WALL3  = 1;  // every gate open only in lane 3
    localparam int K_ALT    = 2;  // gates alternate lane 3 / lane 0
    localparam int K_RAND   = 3;  // LCG cells

    //////////////////////////////////////////////////////////////////////
    // scenario table, expected lane moves (-1 means not counted)
    //////////////////////////////////////////////////////////////////////

    string t_name  [N_TESTS] = '{"free_lane2", "free_lane0", "walled_to_3",
                                 "walled_alt", "random_a", "random_b"};
    int    t_start [N_TESTS] = '{2, 0, 0, 0, 1, 3};
    int    t_kind  [N_TESTS] = '{K_FREE, K_FREE, K_WALL3, K_ALT, K_RAND, K_RAND};
    int    t_steps [N_TESTS] = '{0, 0, 0, 0, 5, 17};
    int    t_moves [N_TESTS] = '{2, 0, 3, 21, -1, -1};

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    lane_t       init;
    cell_t       in0, in1, in2, in3;
    logic        out_valid;
    action_t     out;
    int unsigned seed;
    int          tb_errs;
    int          moves;
    int          n_done, n_failed, n_mism;

    subway_top #(.MAP_COLS(MAP_COLS)) uut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .init(init),
        .in0(in0), .in1(in1), .in2(in2), .in3(in3),
        .out_valid(out_valid), .out(out)
    );

    subway_checker #(.MAP_COLS(MAP_COLS)) u_check (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .init(init),
        .in0(in0), .in1(in1), .in2(in2), .in3(in3),
        .out_valid(out_valid), .out(out),
        .tests_done(n_done), .tests_failed(n_failed), .err_count(n_mism)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    task automatic drive_map(input int k);
        cell_t cells [LANES];
        logic  gate;
        int    r;
        for (int c = 0; c < MAP_COLS; c++) begin
            gate = (c % SEG_LEN == 0) && (c > 0);
            for (int l = 0; l < LANES; l++) begin
                cells[l] = CELL_FREE;
                if (t_kind[k] == K_WALL3 && gate && l < LANES - 1) cells[l] = 2'd2;
                if (t_kind[k] == K_ALT && gate && (c / SEG_LEN) % 2 == 1 && l < LANES - 1)
                    cells[l] = 2'd2;
                if (t_kind[k] == K_RAND) begin
                    seed = lcg_next(seed);
                    r    = (seed >> 16) % 8;
                    if (r >= 7) cells[l] = 2'd2 + cell_t'(seed[20]);  // solid block
                    else if (r >= 5) cells[l] = CELL_LOW;
                end
            end
            @(posedge clk);
            in_valid <= 1'b1;
            init     <= lane_t'(t_start[k]);
            in0      <= cells[0];
            in1      <= cells[1];
            in2      <= cells[2];
            in3      <= cells[3];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        {in3, in2, in1, in0} <= '0;
    endtask

    // counts lane moves until out_valid drops again
    task automatic wait_play(input int k);
        int   n;
        logic seen;
        n     = 0;
        seen  = 1'b0;
        moves = 0;
        while (n < 2 * MAP_COLS + 20) begin
            @(negedge clk);
            n++;
            if (out_valid) begin
                seen = 1'b1;
                if (out == ACT_LEFT || out == ACT_RIGHT) moves++;
            end else if (seen) begin
                break;
            end
        end
        if (!seen) begin
            $display("scenario %s: out_valid never went high", t_name[k]);
            tb_errs++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        init     = '0;
        {in3, in2, in1, in0} = '0;
        seed     = 67;
        tb_errs  = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int k = 0; k < N_TESTS; k++) begin
            repeat (t_steps[k]) seed = lcg_next(seed);
            drive_map(k);
            wait_play(k);
            if (t_moves[k] >= 0 && moves != t_moves[k]) begin
                $display("Fail t=%0t moves in %s: expected %0d got %0d",
                         $time, t_name[k], t_moves[k], moves);
                tb_errs++;
            end
        end
        repeat (2) @(negedge clk);
        $display("tests %0d, failed %0d, mismatches %0d, testbench errors %0d",
                 n_done, n_failed, n_mism, tb_errs);
        if (n_done == N_TESTS && n_failed == 0 && n_mism == 0 && tb_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((N_TESTS * (2 * MAP_COLS + 20) + 16) * 20);
        $display("watchdog expired, simulation did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
subway_map_pkg.sv
subway_action_pkg.sv
map_read_if.sv
subway_map_store.sv
subway_route_planner.sv
subway_play_seq.sv
subway_top.sv
subway_checker.sv
tb_subway_top.sv
